/* include/main_bus_defines.svh */
`ifndef MAIN_BUS_DEFINES_SVH
`define MAIN_BUS_DEFINES_SVH

// bus widths
`define MB_DATA_W 16
`define MB_ADDR_W 23 // word address, A23..A1

// ram word-address widths
`define PALRAM_AW 11
`define TXVRAM_AW 12

// region bases, byte addresses
`define PALRAM_BASE 24'h400000
`define TXVRAM_BASE 24'h500000 // up to 0x501fff
`define IO_BASE     24'h21c000 // 4 KB page
`define GP9001_BASE 24'h300000
`define SOUND_BASE  24'h600000

// byte offsets inside the i/o page
`define IO_IN1    12'h020
`define IO_IN2    12'h024
`define IO_SYS    12'h028
`define IO_DSWA   12'h02c
`define IO_DSWB   12'h030
`define IO_JMPR   12'h034
`define IO_VCOUNT 12'h03c

// low nibble of gp9001 accesses
`define GP_REG_OFF  4'hc
`define GP_SEL_OFF  4'h8
`define GP_RAMH_OFF 4'h4
`define GP_RAML_OFF 4'h6
`define GP_PTR_OFF  4'h0

`endif

/* source/main_bus_pkg.sv */
`default_nettype none

`include "main_bus_defines.svh"

package main_bus_pkg;

    typedef logic [`MB_DATA_W-1:0] bus_word_t;
    typedef logic [`MB_ADDR_W-1:0] bus_addr_t; // A23..A1

    // target of one bus cycle
    typedef enum logic [2:0] {
        dev_none,
        dev_palram,
        dev_txvram,
        dev_io,
        dev_gp9001,
        dev_sound
    } dev_sel_t;

    // operation strobes towards the gp9001, held until ack
    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } gp9001_op_t;

endpackage

`default_nettype wire

/* source/main_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one decoded cpu bus cycle, as registered by the decoder
interface main_bus_if;

    main_bus_pkg::dev_sel_t  dev;
    main_bus_pkg::bus_addr_t addr;
    main_bus_pkg::bus_word_t wdata;
    logic                    rw;  // 1 = read
    logic [1:0]              be;  // {upper, lower}, active high

    modport decoder (
        output dev, addr, wdata, rw, be
    );

    modport ram (
        input dev, addr, wdata, rw, be
    );

    modport responder (
        input dev, addr, wdata, rw, be
    );

endinterface

`default_nettype wire

/* source/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_defines.svh"

module bus_decoder (
    input  logic                    clk96,
    input  logic                    reset96,
    input  main_bus_pkg::bus_addr_t addr,
    input  main_bus_pkg::bus_word_t cpu_dout,
    input  logic                    rw,
    input  logic                    as_n,
    input  logic                    uds_n,
    input  logic                    lds_n,
    main_bus_if.decoder             bus
);

    localparam logic [23:0] pal_base = `PALRAM_BASE;
    localparam logic [23:0] txv_base = `TXVRAM_BASE;
    localparam logic [23:0] io_base  = `IO_BASE;
    localparam logic [23:0] gp_base  = `GP9001_BASE;
    localparam logic [23:0] snd_base = `SOUND_BASE;

    // match the high bits of a byte address against the garegga map
    function automatic main_bus_pkg::dev_sel_t decode(input logic [23:0] a);
        main_bus_pkg::dev_sel_t sel;
        sel = main_bus_pkg::dev_none;
        if (a[23:20] == pal_base[23:20])
            sel = main_bus_pkg::dev_palram;   // 0x400000 - 0x4fffff
        else if (a[23:13] == txv_base[23:13])
            sel = main_bus_pkg::dev_txvram;   // 0x500000 - 0x501fff
        else if (a[23:12] == io_base[23:12])
            sel = main_bus_pkg::dev_io;
        else if (a[23:20] == gp_base[23:20])
            sel = main_bus_pkg::dev_gp9001;
        else if (a[23:20] == snd_base[23:20])
            sel = main_bus_pkg::dev_sound;
        return sel;
    endfunction

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            bus.dev <= main_bus_pkg::dev_none;
        end else if (!as_n) begin
            bus.dev <= decode({addr, 1'b0});
        end else begin
            bus.dev <= main_bus_pkg::dev_none; // idle between cycles
        end
    end

    // cycle payload, only meaningful while dev is not none
    always_ff @(posedge clk96) begin
        if (!as_n) begin
            bus.addr  <= addr;
            bus.wdata <= cpu_dout;
            bus.rw    <= rw;
            bus.be    <= {~uds_n, ~lds_n};
        end
    end

endmodule

`default_nettype wire

/* source/dual_port_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
    parameter int ADDR_W = 11
) (
    input  logic                    clk96,
    // cpu side, read and byte write
    input  logic [ADDR_W-1:0]       cpu_addr,
    input  main_bus_pkg::bus_word_t cpu_wdata,
    input  logic [1:0]              cpu_we,
    output main_bus_pkg::bus_word_t cpu_q,
    // video side, read only
    input  logic [ADDR_W-1:0]       vid_addr,
    output main_bus_pkg::bus_word_t vid_q
);

    main_bus_pkg::bus_word_t mem [2**ADDR_W];

    always_ff @(posedge clk96) begin
        if (cpu_we[1]) begin
            mem[cpu_addr][15:8] <= cpu_wdata[15:8];
        end
        if (cpu_we[0]) begin
            mem[cpu_addr][7:0] <= cpu_wdata[7:0];
        end
        cpu_q <= mem[cpu_addr]; // old data on a write cycle
    end

    always_ff @(posedge clk96) begin
        vid_q <= mem[vid_addr];
    end

endmodule

`default_nettype wire

/* source/video_ram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_defines.svh"

module video_ram_bank (
    input  logic                    clk96,
    main_bus_if.ram                 bus,
    // video side
    input  logic [`PALRAM_AW-1:0]   palram_addr,
    output main_bus_pkg::bus_word_t palram_data,
    input  logic [`TXVRAM_AW-1:0]   txvram_addr,
    output main_bus_pkg::bus_word_t txvram_data,
    // cpu read words towards the responder
    output main_bus_pkg::bus_word_t palram_q,
    output main_bus_pkg::bus_word_t txvram_q
);

    logic [1:0]            pal_we;
    logic [1:0]            txv_we;
    logic [`PALRAM_AW-1:0] pal_cpu_addr;
    logic [`TXVRAM_AW-1:0] txv_cpu_addr;

    // byte lanes only on a write cycle to that ram
    assign pal_we = {2{bus.dev == main_bus_pkg::dev_palram && !bus.rw}} & bus.be;
    assign txv_we = {2{bus.dev == main_bus_pkg::dev_txvram && !bus.rw}} & bus.be;

    assign pal_cpu_addr = bus.addr[`PALRAM_AW-1:0]; // A11..A1
    assign txv_cpu_addr = bus.addr[`TXVRAM_AW-1:0]; // A12..A1

    // palette ram, 0x400000
    dual_port_ram #(
        .ADDR_W (`PALRAM_AW)
    ) u_palram (
        .clk96     (clk96),
        .cpu_addr  (pal_cpu_addr),
        .cpu_wdata (bus.wdata),
        .cpu_we    (pal_we),
        .cpu_q     (palram_q),
        .vid_addr  (palram_addr),
        .vid_q     (palram_data)
    );

    // text vram, 0x500000
    dual_port_ram #(
        .ADDR_W (`TXVRAM_AW)
    ) u_txvram (
        .clk96     (clk96),
        .cpu_addr  (txv_cpu_addr),
        .cpu_wdata (bus.wdata),
        .cpu_we    (txv_we),
        .cpu_q     (txvram_q),
        .vid_addr  (txvram_addr),
        .vid_q     (txvram_data)
    );

endmodule

`default_nettype wire

/* source/bus_responder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_defines.svh"

module bus_responder (
    input  logic                     clk96,
    input  logic                     reset96,
    main_bus_if.responder            bus,
    input  main_bus_pkg::bus_word_t  palram_q,
    input  main_bus_pkg::bus_word_t  txvram_q,
    input  main_bus_pkg::bus_word_t  gp9001_dout,
    input  logic                     gp9001_ack,
    input  logic [9:0]               joystick1,
    input  logic [9:0]               joystick2,
    input  logic [3:0]               start_button,
    input  logic [3:0]               coin_input,
    input  logic                     service,
    input  logic                     dip_test,
    input  logic [7:0]               dipsw_a,
    input  logic [7:0]               dipsw_b,
    input  logic [7:0]               dipsw_c,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     fblank,
    input  logic [8:0]               v,
    output main_bus_pkg::bus_word_t  cpu_din,
    output logic [7:0]               sound_latch,
    output logic                     z80_int,
    output main_bus_pkg::gp9001_op_t gp9001_op
);

    logic [11:0]             io_off;
    logic [3:0]              gp_off;
    logic                    io_rd;
    logic                    gp_rd;
    logic                    gp_wr;
    logic                    sound_wr;
    logic [7:0]              p1_ctrl;
    logic [7:0]              p2_ctrl;
    logic [7:0]              sys_ctrl;
    main_bus_pkg::bus_word_t video_status;
    main_bus_pkg::bus_word_t rdata;

    assign io_off   = {bus.addr[10:0], 1'b0}; // byte offset in the i/o page
    assign gp_off   = {bus.addr[2:0], 1'b0};
    assign io_rd    = bus.dev == main_bus_pkg::dev_io && bus.rw;
    assign gp_rd    = bus.dev == main_bus_pkg::dev_gp9001 && bus.rw;
    assign gp_wr    = bus.dev == main_bus_pkg::dev_gp9001 && !bus.rw;
    assign sound_wr = bus.dev == main_bus_pkg::dev_sound && !bus.rw;

    // cabinet inputs are active high here and the game expects active low
    assign p1_ctrl  = {1'b0, ~joystick1[6], ~joystick1[5], ~joystick1[4],
                       ~joystick1[0], ~joystick1[1], ~joystick1[2], ~joystick1[3]};
    assign p2_ctrl  = {1'b0, ~joystick2[6], ~joystick2[5], ~joystick2[4],
                       ~joystick2[0], ~joystick2[1], ~joystick2[2], ~joystick2[3]};
    assign sys_ctrl = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                       ~coin_input[0], ~dip_test, 1'b0, ~service};

    // sync and blank bits over a line count that saturates at 0xff
    assign video_status = {hsync, vsync, 5'b11111, fblank, v[8] ? 8'hff : v[7:0]};

    always_comb begin
        rdata = '0;
        if (bus.dev == main_bus_pkg::dev_palram && bus.rw) begin
            rdata = palram_q;
        end else if (bus.dev == main_bus_pkg::dev_txvram && bus.rw) begin
            rdata = txvram_q;
        end else if (gp_rd) begin
            rdata = gp9001_dout;
        end else if (io_rd) begin
            case (io_off)
                `IO_IN1:    rdata = {2{p1_ctrl}};
                `IO_IN2:    rdata = {2{p2_ctrl}};
                `IO_SYS:    rdata = {dipsw_c, sys_ctrl};
                `IO_DSWA:   rdata = {2{dipsw_a}};
                `IO_DSWB:   rdata = {2{dipsw_b}};
                `IO_JMPR:   rdata = {2{dipsw_c}};
                `IO_VCOUNT: rdata = video_status;
                default:    rdata = '0; // coin counter and the rest
            endcase
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            cpu_din <= '0;
        end else begin
            cpu_din <= rdata;
        end
    end

    // sound latch towards the z80
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            sound_latch <= 8'h00;
            z80_int     <= 1'b0;
        end else begin
            if (sound_wr) begin
                sound_latch <= bus.wdata[7:0];
            end
            z80_int <= sound_wr; // high for the rest of the write cycle
        end
    end

    // gp9001 strobes accumulate until acknowledged outside an i/o access
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            gp9001_op <= '0;
        end else if (gp_rd) begin
            case (gp_off)
                `GP_RAMH_OFF: gp9001_op.read_ram_h <= 1'b1;
                `GP_RAML_OFF: gp9001_op.read_ram_l <= 1'b1;
                default: ;
            endcase
        end else if (gp_wr) begin
            case (gp_off)
                `GP_REG_OFF:               gp9001_op.write_reg   <= 1'b1;
                `GP_SEL_OFF:               gp9001_op.select_reg  <= 1'b1;
                `GP_RAMH_OFF, `GP_RAML_OFF: gp9001_op.write_ram  <= 1'b1;
                `GP_PTR_OFF:               gp9001_op.set_ram_ptr <= 1'b1;
                default: ;
            endcase
        end else if (bus.dev != main_bus_pkg::dev_io && gp9001_ack) begin
            gp9001_op <= '0;
        end
    end

endmodule

`default_nettype wire

/* source/main_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_defines.svh"

module main_bus_top (
    input  logic                     clk96,
    input  logic                     reset96,
    // 68000 bus
    input  main_bus_pkg::bus_addr_t  addr,
    input  main_bus_pkg::bus_word_t  cpu_dout,
    input  logic                     rw,
    input  logic                     as_n,
    input  logic                     uds_n,
    input  logic                     lds_n,
    output main_bus_pkg::bus_word_t  cpu_din,
    // video side of the rams
    input  logic [`PALRAM_AW-1:0]    palram_addr,
    output main_bus_pkg::bus_word_t  palram_data,
    input  logic [`TXVRAM_AW-1:0]    txvram_addr,
    output main_bus_pkg::bus_word_t  txvram_data,
    // gp9001
    input  main_bus_pkg::bus_word_t  gp9001_dout,
    input  logic                     gp9001_ack,
    output main_bus_pkg::gp9001_op_t gp9001_op,
    // cabinet and dips
    input  logic [9:0]               joystick1,
    input  logic [9:0]               joystick2,
    input  logic [3:0]               start_button,
    input  logic [3:0]               coin_input,
    input  logic                     service,
    input  logic                     dip_test,
    input  logic [7:0]               dipsw_a,
    input  logic [7:0]               dipsw_b,
    input  logic [7:0]               dipsw_c,
    // video timing
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     fblank,
    input  logic [8:0]               v,
    // sound cpu
    output logic [7:0]               sound_latch,
    output logic                     z80_int
);

    main_bus_pkg::bus_word_t palram_q;
    main_bus_pkg::bus_word_t txvram_q;

    main_bus_if bus0 ();

    bus_decoder u_decoder (
        .clk96    (clk96),
        .reset96  (reset96),
        .addr     (addr),
        .cpu_dout (cpu_dout),
        .rw       (rw),
        .as_n     (as_n),
        .uds_n    (uds_n),
        .lds_n    (lds_n),
        .bus      (bus0.decoder)
    );

    video_ram_bank u_rams (
        .clk96       (clk96),
        .bus         (bus0.ram),
        .palram_addr (palram_addr),
        .palram_data (palram_data),
        .txvram_addr (txvram_addr),
        .txvram_data (txvram_data),
        .palram_q    (palram_q),
        .txvram_q    (txvram_q)
    );

    bus_responder u_responder (
        .clk96        (clk96),
        .reset96      (reset96),
        .bus          (bus0.responder),
        .palram_q     (palram_q),
        .txvram_q     (txvram_q),
        .gp9001_dout  (gp9001_dout),
        .gp9001_ack   (gp9001_ack),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .hsync        (hsync),
        .vsync        (vsync),
        .fblank       (fblank),
        .v            (v),
        .cpu_din      (cpu_din),
        .sound_latch  (sound_latch),
        .z80_int      (z80_int),
        .gp9001_op    (gp9001_op)
    );

endmodule

`default_nettype wire

/* verification/main_bus_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_defines.svh"

module main_bus_checker (
    input  logic                     clk96,
    input  logic                     reset96,
    input  main_bus_pkg::bus_addr_t  addr,
    input  main_bus_pkg::bus_word_t  cpu_dout,
    input  logic                     rw,
    input  logic                     as_n,
    input  logic                     uds_n,
    input  logic                     lds_n,
    input  main_bus_pkg::bus_word_t  cpu_din,
    input  logic [`PALRAM_AW-1:0]    palram_addr,
    input  main_bus_pkg::bus_word_t  palram_data,
    input  logic [`TXVRAM_AW-1:0]    txvram_addr,
    input  main_bus_pkg::bus_word_t  txvram_data,
    input  main_bus_pkg::bus_word_t  gp9001_dout,
    input  logic                     gp9001_ack,
    input  main_bus_pkg::gp9001_op_t gp9001_op,
    input  logic [9:0]               joystick1,
    input  logic [9:0]               joystick2,
    input  logic [3:0]               start_button,
    input  logic [3:0]               coin_input,
    input  logic                     service,
    input  logic                     dip_test,
    input  logic [7:0]               dipsw_a,
    input  logic [7:0]               dipsw_b,
    input  logic [7:0]               dipsw_c,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     fblank,
    input  logic [8:0]               v,
    input  logic [7:0]               sound_latch,
    input  logic                     z80_int,
    output int                       errors
);

    main_bus_pkg::bus_word_t  pal_shadow [2**`PALRAM_AW];
    main_bus_pkg::bus_word_t  txv_shadow [2**`TXVRAM_AW];
    main_bus_pkg::gp9001_op_t exp_op;
    main_bus_pkg::dev_sel_t   cyc_dev;
    logic [23:0]              cyc_addr; // byte address
    main_bus_pkg::bus_word_t  cyc_data;
    logic                     cyc_read;
    logic [1:0]               cyc_be;
    logic                     sound_done;
    int                       low_n;    // edges with as_n low
    int                       idle_n;   // edges with as_n high
    logic [`PALRAM_AW-1:0]    pal_vaddr;
    logic [`TXVRAM_AW-1:0]    txv_vaddr;

    initial errors = 0;

    function automatic main_bus_pkg::dev_sel_t target(input logic [23:0] a);
        if (a >= `PALRAM_BASE && a < `PALRAM_BASE + 24'h100000)
            return main_bus_pkg::dev_palram;
        if (a >= `TXVRAM_BASE && a <= `TXVRAM_BASE + 24'h1fff)
            return main_bus_pkg::dev_txvram;
        if (a >= `IO_BASE && a < `IO_BASE + 24'h1000)
            return main_bus_pkg::dev_io;
        if (a >= `GP9001_BASE && a < `GP9001_BASE + 24'h100000)
            return main_bus_pkg::dev_gp9001;
        if (a >= `SOUND_BASE && a < `SOUND_BASE + 24'h100000)
            return main_bus_pkg::dev_sound;
        return main_bus_pkg::dev_none;
    endfunction

    // inverted stick bits, same byte twice
    function automatic logic [15:0] player_word(input logic [9:0] j);
        logic [7:0] b;
        b = {1'b0, ~j[6], ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
        return {b, b};
    endfunction

    function automatic logic [15:0] system_word();
        logic [7:0] b;
        b = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
             ~coin_input[0], ~dip_test, 1'b0, ~service};
        return {dipsw_c, b};
    endfunction

    function automatic logic [15:0] status_word();
        logic [15:0] w;
        w = 16'hff00;
        if (!hsync)
            w[15] = 1'b0;
        if (!vsync)
            w[14] = 1'b0;
        if (!fblank)
            w[8] = 1'b0;
        return w | ((v >= 9'd256) ? 16'h00ff : {8'h00, v[7:0]});
    endfunction

    function automatic logic [15:0] io_word(input logic [11:0] off);
        case (off)
            `IO_IN1:    return player_word(joystick1);
            `IO_IN2:    return player_word(joystick2);
            `IO_SYS:    return system_word();
            `IO_DSWA:   return {dipsw_a, dipsw_a};
            `IO_DSWB:   return {dipsw_b, dipsw_b};
            `IO_JMPR:   return {dipsw_c, dipsw_c};
            `IO_VCOUNT: return status_word();
            default:    return 16'h0000;
        endcase
    endfunction

    function automatic main_bus_pkg::gp9001_op_t gp_strobe(input logic [3:0] nib,
                                                           input logic read);
        main_bus_pkg::gp9001_op_t op;
        op = '0;
        if (read) begin
            op.read_ram_h = nib == `GP_RAMH_OFF;
            op.read_ram_l = nib == `GP_RAML_OFF;
        end else begin
            op.write_reg   = nib == `GP_REG_OFF;
            op.select_reg  = nib == `GP_SEL_OFF;
            op.write_ram   = nib == `GP_RAMH_OFF || nib == `GP_RAML_OFF;
            op.set_ram_ptr = nib == `GP_PTR_OFF;
        end
        return op;
    endfunction

    function automatic logic [15:0] expected_read();
        case (cyc_dev)
            main_bus_pkg::dev_palram: return pal_shadow[cyc_addr[`PALRAM_AW:1]];
            main_bus_pkg::dev_txvram: return txv_shadow[cyc_addr[`TXVRAM_AW:1]];
            main_bus_pkg::dev_io:     return io_word(cyc_addr[11:0]);
            main_bus_pkg::dev_gp9001: return gp9001_dout;
            default:                  return 16'h0000;
        endcase
    endfunction

    function automatic string read_name();
        case (cyc_dev)
            main_bus_pkg::dev_palram: return "palram read";
            main_bus_pkg::dev_txvram: return "txvram read";
            main_bus_pkg::dev_io:     return "io read";
            main_bus_pkg::dev_gp9001: return "gp9001 read";
            default:                  return "unmapped read";
        endcase
    endfunction

    function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] wr,
                                          input logic [1:0] be);
        return {be[1] ? wr[15:8] : old[15:8], be[0] ? wr[7:0] : old[7:0]};
    endfunction

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    always @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            exp_op     = '0;
            low_n      = 0;
            idle_n     = 0;
            sound_done = 1'b0;
        end else begin
            // bus quiet for two edges, rams and strobes settled
            if (idle_n >= 2) begin
                check("palram video", pal_shadow[pal_vaddr], palram_data);
                check("txvram video", txv_shadow[txv_vaddr], txvram_data);
                check("gp9001 strobes idle", exp_op, gp9001_op);
            end
            if (idle_n == 2 && sound_done) begin
                check("z80_int release", 16'h0, z80_int);
                sound_done = 1'b0;
            end
            pal_vaddr = palram_addr;
            txv_vaddr = txvram_addr;
            if (!as_n) begin
                low_n++;
                idle_n = 0;
                if (low_n == 1) begin
                    cyc_addr = {addr, 1'b0};
                    cyc_data = cpu_dout;
                    cyc_read = rw;
                    cyc_be   = {~uds_n, ~lds_n};
                    cyc_dev  = target(cyc_addr);
                    if (cyc_dev == main_bus_pkg::dev_gp9001)
                        exp_op = exp_op | gp_strobe(cyc_addr[3:0], cyc_read);
                end
                if (low_n == 6) begin
                    if (cyc_read)
                        check(read_name(), expected_read(), cpu_din);
                    if (cyc_dev == main_bus_pkg::dev_gp9001)
                        check("gp9001 strobes", exp_op, gp9001_op);
                    if (cyc_dev == main_bus_pkg::dev_sound && !cyc_read) begin
                        check("sound latch", cyc_data[7:0], sound_latch);
                        check("z80_int", 16'h1, z80_int);
                    end
                end
            end else begin
                if (low_n > 0 && !cyc_read) begin
                    if (cyc_dev == main_bus_pkg::dev_palram)
                        pal_shadow[cyc_addr[`PALRAM_AW:1]] =
                            merge(pal_shadow[cyc_addr[`PALRAM_AW:1]], cyc_data, cyc_be);
                    if (cyc_dev == main_bus_pkg::dev_txvram)
                        txv_shadow[cyc_addr[`TXVRAM_AW:1]] =
                            merge(txv_shadow[cyc_addr[`TXVRAM_AW:1]], cyc_data, cyc_be);
                    sound_done = cyc_dev == main_bus_pkg::dev_sound;
                end
                low_n = 0;
                idle_n++;
                if (gp9001_ack && idle_n >= 2)
                    exp_op = '0; // ack seen with no access decoded
            end
        end
    end

endmodule

`default_nettype wire

/* verification/main_bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_defines.svh"

module main_bus_tb;

    localparam int hold_cycles = 8;
    localparam int wait_limit  = 100;

    logic                     clk96;
    logic                     reset96;
    main_bus_pkg::bus_addr_t  addr;
    main_bus_pkg::bus_word_t  cpu_dout;
    logic                     rw;
    logic                     as_n;
    logic                     uds_n;
    logic                     lds_n;
    main_bus_pkg::bus_word_t  cpu_din;
    logic [`PALRAM_AW-1:0]    palram_addr;
    main_bus_pkg::bus_word_t  palram_data;
    logic [`TXVRAM_AW-1:0]    txvram_addr;
    main_bus_pkg::bus_word_t  txvram_data;
    main_bus_pkg::bus_word_t  gp9001_dout;
    logic                     gp9001_ack;
    main_bus_pkg::gp9001_op_t gp9001_op;
    logic [9:0]               joystick1;
    logic [9:0]               joystick2;
    logic [3:0]               start_button;
    logic [3:0]               coin_input;
    logic                     service;
    logic                     dip_test;
    logic [7:0]               dipsw_a;
    logic [7:0]               dipsw_b;
    logic [7:0]               dipsw_c;
    logic                     hsync;
    logic                     vsync;
    logic                     fblank;
    logic [8:0]               v;
    logic [7:0]               sound_latch;
    logic                     z80_int;

    int                       errors;   // from the checker
    int                       timeouts;
    integer                   seed;
    int                       i;
    main_bus_pkg::bus_word_t  data;
    logic [`TXVRAM_AW-1:0]    txv_idx;

    main_bus_top dut0 (.*);

    main_bus_checker chk0 (.*);

    initial begin
        clk96 = 1'b0;
        forever #20 clk96 = ~clk96;
    end

    // one 68000 cycle, held for a fixed number of clocks
    task automatic bus_cycle(input logic read, input logic [23:0] byte_addr,
                             input main_bus_pkg::bus_word_t wdata, input logic [1:0] be);
        @(negedge clk96);
        addr     = byte_addr[23:1];
        cpu_dout = wdata;
        rw       = read;
        uds_n    = ~be[1];
        lds_n    = ~be[0];
        as_n     = 1'b0;
        repeat (hold_cycles) @(negedge clk96);
        as_n = 1'b1;
        repeat (3) @(negedge clk96); // bus idle
    endtask

    task automatic video_read(input logic [`PALRAM_AW-1:0] pa,
                              input logic [`TXVRAM_AW-1:0] ta);
        @(negedge clk96);
        palram_addr = pa;
        txvram_addr = ta;
        repeat (2) @(negedge clk96);
    endtask

    // full word, then upper only, then lower only
    task automatic pal_test(input logic [`PALRAM_AW-1:0] idx);
        logic [23:0] a;
        a = `PALRAM_BASE + {idx, 1'b0};
        data = $random(seed);
        bus_cycle(1'b0, a, data, 2'b11);
        bus_cycle(1'b1, a, 16'h0, 2'b11);
        data = $random(seed);
        bus_cycle(1'b0, a, data, 2'b10);
        bus_cycle(1'b1, a, 16'h0, 2'b11);
        data = $random(seed);
        bus_cycle(1'b0, a, data, 2'b01);
        bus_cycle(1'b1, a, 16'h0, 2'b11);
        video_read(idx, txvram_addr);
    endtask

    task automatic randomize_inputs;
        @(negedge clk96);
        joystick1    = $random(seed);
        joystick2    = $random(seed);
        start_button = $random(seed);
        coin_input   = $random(seed);
        service      = $random(seed);
        dip_test     = $random(seed);
        dipsw_a      = $random(seed);
        dipsw_b      = $random(seed);
        dipsw_c      = $random(seed);
    endtask

    task automatic io_read(input logic [11:0] off);
        bus_cycle(1'b1, `IO_BASE + off, 16'h0, 2'b11);
    endtask

    task automatic gp_access(input logic read, input logic [3:0] nib);
        data = $random(seed);
        bus_cycle(read, `GP9001_BASE + nib, data, 2'b11);
    endtask

    // raise ack outside any access until the strobes drop
    task automatic ack_strobes;
        int n;
        n = 0;
        @(negedge clk96);
        gp9001_ack = 1'b1;
        while (gp9001_op != '0 && n < wait_limit) begin
            @(negedge clk96);
            n++;
        end
        if (gp9001_op != '0) begin
            $display("timeout: gp9001 strobes still set after %0d cycles of ack", n);
            timeouts++;
        end
        gp9001_ack = 1'b0;
        repeat (2) @(negedge clk96);
    endtask

    task automatic wait_z80_low;
        int n;
        n = 0;
        while (z80_int && n < wait_limit) begin
            @(negedge clk96);
            n++;
        end
        if (z80_int) begin
            $display("timeout: z80_int never dropped after the sound write");
            timeouts++;
        end
    endtask

    initial begin
        seed         = 32'hd9a339e2;
        timeouts     = 0;
        reset96      = 1'b1;
        addr         = '0;
        cpu_dout     = '0;
        rw           = 1'b1;
        as_n         = 1'b1;
        uds_n        = 1'b1;
        lds_n        = 1'b1;
        palram_addr  = '0;
        txvram_addr  = '0;
        gp9001_dout  = '0;
        gp9001_ack   = 1'b0;
        joystick1    = '0;
        joystick2    = '0;
        start_button = '0;
        coin_input   = '0;
        service      = 1'b0;
        dip_test     = 1'b0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        dipsw_c      = '0;
        hsync        = 1'b1;
        vsync        = 1'b1;
        fblank       = 1'b1;
        v            = '0;
        repeat (4) @(negedge clk96);
        reset96 = 1'b0;
        repeat (2) @(negedge clk96);

        for (i = 0; i < 12; i++) begin
            pal_test($random(seed));
        end

        for (i = 0; i < 12; i++) begin
            txv_idx = $random(seed);
            data    = $random(seed);
            bus_cycle(1'b0, `TXVRAM_BASE + {txv_idx, 1'b0}, data, 2'b11);
            bus_cycle(1'b1, `TXVRAM_BASE + {txv_idx, 1'b0}, 16'h0, 2'b11);
            video_read(palram_addr, txv_idx);
        end

        for (i = 0; i < 8; i++) begin
            randomize_inputs();
            io_read(`IO_IN1);
            io_read(`IO_IN2);
            io_read(`IO_SYS);
            io_read(`IO_DSWA);
            io_read(`IO_DSWB);
            io_read(`IO_JMPR);
            io_read(12'h038); // unmapped
        end

        // line count on both sides of 256
        for (i = 0; i < 16; i++) begin
            @(negedge clk96);
            hsync  = $random(seed);
            vsync  = $random(seed);
            fblank = $random(seed);
            v      = {i[0], 8'($random(seed))};
            io_read(`IO_VCOUNT);
        end

        for (i = 0; i < 4; i++) begin
            data = $random(seed);
            bus_cycle(1'b0, `SOUND_BASE, data, 2'b11);
            wait_z80_low();
        end

        gp_access(1'b0, `GP_REG_OFF);
        repeat (6) @(negedge clk96); // no ack, strobe must hold
        ack_strobes();
        gp_access(1'b0, `GP_SEL_OFF);
        ack_strobes();
        gp_access(1'b0, `GP_RAMH_OFF);
        ack_strobes();
        gp_access(1'b0, `GP_RAML_OFF);
        ack_strobes();
        gp_access(1'b0, `GP_PTR_OFF);
        ack_strobes();
        gp9001_dout = $random(seed);
        gp_access(1'b1, `GP_RAMH_OFF);
        ack_strobes();
        gp9001_dout = $random(seed);
        gp_access(1'b1, `GP_RAML_OFF);
        ack_strobes();
        // strobes pile up while unacknowledged
        gp_access(1'b0, `GP_SEL_OFF);
        gp_access(1'b0, `GP_REG_OFF);
        repeat (6) @(negedge clk96);
        ack_strobes();

        repeat (4) @(negedge clk96);
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
source/main_bus_pkg.sv
source/main_bus_if.sv
source/bus_decoder.sv
source/dual_port_ram.sv
source/video_ram_bank.sv
source/bus_responder.sv
source/main_bus_top.sv
verification/main_bus_checker.sv
verification/main_bus_tb.sv

/* Bender.yml */
package:
  name: main_bus

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/main_bus_pkg.sv
      - source/main_bus_if.sv
      - source/bus_decoder.sv
      - source/dual_port_ram.sv
      - source/video_ram_bank.sv
      - source/bus_responder.sv
      - source/main_bus_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/main_bus_checker.sv
      - verification/main_bus_tb.sv
